// ==== build.f ====
+incdir+hdl
hdl/soc_pkg.sv
hdl/wb_timer.sv
hdl/wb_ram.sv
hdl/periph_bus.sv
hdl/bus_decoder.sv
hdl/soc_top.sv
dv/soc_tb.sv

// ==== Makefile ====
# Verilator flow for the bus fabric

VERILATOR  ?= verilator
FILELIST   ?= build.f
TB_TOP     ?= soc_tb
RTL_TOP    ?= soc_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

# Pass or fail comes from the pass line in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/soc_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module soc_tb;
    import soc_pkg::*;

    localparam int RAM_WORDS  = 16;
    localparam int POLL_LIMIT = 64;
    localparam int CMP_MARGIN = 20;
    localparam int NUM_TESTS  = 5;

    // Idle cycles from the start of polling until the match flag is seen
    localparam int IRQ_POLLS  = CMP_MARGIN - 2;

    // Cycles per test summed into the run limit
    localparam int LEN_RESET   = 12;
    localparam int LEN_RAM     = 8 * RAM_WORDS + 8;
    localparam int LEN_GPIO    = 16;
    localparam int LEN_TIMER   = 16 + POLL_LIMIT;
    localparam int LEN_ERRORS  = 12;
    localparam int CYCLE_LIMIT = LEN_RESET + LEN_RAM + LEN_GPIO + LEN_TIMER + LEN_ERRORS + 40;

    localparam int RSP_ACK = 1;
    localparam int RSP_ERR = 2;

    localparam wb_addr_t ADR_UNMAPPED = 28'h800_0000; // Byte 0x2000_0000
    localparam wb_addr_t ADR_HOLE     = 28'h400_4000; // Byte 0x1001_0000 with no peripheral

    logic      sys_clk;
    logic      arst_n_i;
    logic      cyc_i;
    logic      stb_i;
    logic      we_i;
    wb_addr_t  adr_i;
    word_t     dat_i;
    byte_sel_t sel_i;
    logic      ack_o;
    logic      err_o;
    word_t     dat_o;
    gpio_t     gpio_i;
    gpio_t     gpio_o;
    logic      timer_irq_o;

    logic [15:0] lfsr_q = 16'd63;
    word_t       ram_model [0:(1 << `RAM_AW)-1];
    ram_addr_t   ram_addr [RAM_WORDS];
    int          err_count = 0;
    int          fail_count = 0;
    int          cycles = 0;

    soc_top UUT (
        .sys_clk     (sys_clk),
        .arst_n_i    (arst_n_i),
        .cyc_i       (cyc_i),
        .stb_i       (stb_i),
        .we_i        (we_i),
        .adr_i       (adr_i),
        .dat_i       (dat_i),
        .sel_i       (sel_i),
        .ack_o       (ack_o),
        .err_o       (err_o),
        .dat_o       (dat_o),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .timer_irq_o (timer_irq_o)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[`SOC_DW-2:0], lfsr_q[15]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Word address of a register inside a window
    function automatic wb_addr_t win_addr(input wb_addr_t base, input int idx);
        return base + wb_addr_t'(idx);
    endfunction

    // Only the selected byte lanes take the new data
    function automatic word_t merge_bytes(input word_t old, input word_t upd,
                                          input byte_sel_t sel);
        word_t w;
        w = old;
        for (int b = 0; b < `SOC_SELW; b++)
        begin
            if (sel[b])
                w[b*8 +: 8] = upd[b*8 +: 8];
        end
        return w;
    endfunction

    task automatic check_val(input string name, input word_t exp, input word_t act);
        assert (act === exp)
        else
        begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    // Starts and ends at a drive point
    task automatic bus_req(input logic we, input wb_addr_t adr, input word_t dat,
                           input byte_sel_t sel, input int rsp, output word_t rdata);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = we;
        adr_i = adr;
        dat_i = dat;
        sel_i = sel;
        @(posedge sys_clk);
        #1;
        check_val("ack_o", word_t'(rsp == RSP_ACK), word_t'(ack_o));
        check_val("err_o", word_t'(rsp == RSP_ERR), word_t'(err_o));
        rdata = dat_o;
        #1;
    endtask

    task automatic bus_write(input wb_addr_t adr, input word_t dat, input byte_sel_t sel,
                             input int rsp);
        word_t r;
        bus_req(1'b1, adr, dat, sel, rsp, r);
    endtask

    task automatic bus_read(input wb_addr_t adr, input int rsp, output word_t rdata);
        bus_req(1'b0, adr, '0, 4'hF, rsp, rdata);
    endtask

    task automatic read_check(input wb_addr_t adr, input word_t exp);
        word_t r;
        bus_read(adr, RSP_ACK, r);
        check_val("dat_o", exp, r);
    endtask

    task automatic bus_idle();
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
        @(posedge sys_clk);
        #1;
        check_val("ack_o", '0, word_t'(ack_o)); // Nothing may answer an idle cycle
        check_val("err_o", '0, word_t'(err_o));
        #1;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;
        errs = err_count - errs_before;
        if (errs == 0)
            $display("test %s: passed", name);
        else
        begin
            $display("test %s: failed with %0d errors", name, errs);
            fail_count++;
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = err_count;
        check_val("ack_o", '0, word_t'(ack_o));
        check_val("err_o", '0, word_t'(err_o));
        check_val("gpio_o", '0, word_t'(gpio_o));
        check_val("timer_irq_o", '0, word_t'(timer_irq_o));
        repeat (3) bus_idle();
        // Count and compare both start at zero and still no match is flagged
        check_val("timer_irq_o", '0, word_t'(timer_irq_o));
        finish_test("reset", e0);
    endtask

    task automatic test_ram();
        int    e0;
        word_t a;
        word_t d;
        word_t s;
        e0 = err_count;
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            rand_bits(`RAM_AW, a);
            rand_bits(`SOC_DW, d);
            ram_addr[i] = ram_addr_t'(a);
            ram_model[ram_addr[i]] = d;
            bus_write(win_addr(`RAM_BASE, int'(ram_addr[i])), d, 4'hF, RSP_ACK);
            bus_idle();
        end
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            rand_bits(`SOC_DW, d);
            rand_bits(`SOC_SELW, s);
            ram_model[ram_addr[i]] = merge_bytes(ram_model[ram_addr[i]], d, byte_sel_t'(s));
            bus_write(win_addr(`RAM_BASE, int'(ram_addr[i])), d, byte_sel_t'(s), RSP_ACK);
            bus_idle();
        end
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            read_check(win_addr(`RAM_BASE, int'(ram_addr[i])), ram_model[ram_addr[i]]);
            bus_idle();
        end
        // Back-to-back reads give one response per cycle
        for (int i = 0; i < RAM_WORDS; i++)
            read_check(win_addr(`RAM_BASE, int'(ram_addr[i])), ram_model[ram_addr[i]]);
        bus_idle();
        finish_test("ram", e0);
    endtask

    task automatic test_gpio();
        int    e0;
        word_t d;
        e0 = err_count;
        rand_bits(`SOC_DW, d);
        bus_write(win_addr(`GPIO_BASE, int'(`GPIO_REG_OUT)), d, 4'hF, RSP_ACK);
        bus_idle();
        check_val("gpio_o", word_t'(d[7:0]), word_t'(gpio_o));
        bus_write(win_addr(`GPIO_BASE, int'(`GPIO_REG_OUT)), ~d, 4'hE, RSP_ACK); // Lane 0 off
        bus_idle();
        check_val("gpio_o", word_t'(d[7:0]), word_t'(gpio_o));
        read_check(win_addr(`GPIO_BASE, int'(`GPIO_REG_OUT)), word_t'(d[7:0]));
        rand_bits(8, d);
        gpio_i = gpio_t'(d);
        bus_idle();
        read_check(win_addr(`GPIO_BASE, int'(`GPIO_REG_IN)), word_t'(d[7:0]));
        bus_idle();
        finish_test("gpio", e0);
    endtask

    task automatic test_timer();
        int    e0;
        int    n;
        word_t d;
        word_t cnt;
        word_t cmp;
        e0 = err_count;
        rand_bits(16, d);
        bus_write(win_addr(`TIMER_BASE, int'(`TIMER_REG_COUNT)), d, 4'hF, RSP_ACK);
        bus_idle();
        bus_read(win_addr(`TIMER_BASE, int'(`TIMER_REG_COUNT)), RSP_ACK, cnt);
        assert (cnt > d)
        else
        begin
            $display("** Error at %0t ns: dat_o expected above %h, got %h", $time, d, cnt);
            err_count++;
        end
        cmp = cnt + CMP_MARGIN;
        bus_write(win_addr(`TIMER_BASE, int'(`TIMER_REG_CMP)), cmp, 4'hF, RSP_ACK);
        check_val("timer_irq_o", '0, word_t'(timer_irq_o));
        read_check(win_addr(`TIMER_BASE, int'(`TIMER_REG_CMP)), cmp);
        // Count reaches cmp CMP_MARGIN cycles after the read and the flag follows a cycle later
        n = 0;
        while (timer_irq_o !== 1'b1 && n < POLL_LIMIT)
        begin
            bus_idle();
            n++;
        end
        assert (timer_irq_o === 1'b1)
        else
        begin
            $display("At %0t ns the timer interrupt had not risen after %0d cycles",
                     $time, POLL_LIMIT);
            err_count++;
        end
        assert (n == IRQ_POLLS)
        else
        begin
            $display("At %0t ns the timer interrupt rose after %0d idle cycles instead of %0d",
                     $time, n, IRQ_POLLS);
            err_count++;
        end
        bus_write(win_addr(`TIMER_BASE, int'(`TIMER_REG_CMP)), ~cmp, 4'hF, RSP_ACK);
        bus_idle();
        check_val("timer_irq_o", '0, word_t'(timer_irq_o));
        finish_test("timer", e0);
    endtask

    task automatic test_errors();
        int    e0;
        word_t d;
        word_t r;
        e0 = err_count;
        rand_bits(`SOC_DW, d);
        bus_write(ADR_UNMAPPED, d, 4'hF, RSP_ERR);
        bus_write(win_addr(`RAM_BASE, int'(ram_addr[0])), d, 4'hF, RSP_ACK);
        ram_model[ram_addr[0]] = d;
        bus_read(ADR_HOLE, RSP_ERR, r);
        read_check(win_addr(`RAM_BASE, int'(ram_addr[0])), d);
        bus_idle();
        bus_read(ADR_UNMAPPED, RSP_ERR, r);
        bus_write(ADR_HOLE, ~d, 4'hF, RSP_ERR);
        read_check(win_addr(`RAM_BASE, int'(ram_addr[0])), d);
        bus_idle();
        finish_test("errors", e0);
    endtask

    initial
    begin
        arst_n_i = 1'b0;
        cyc_i    = 1'b0;
        stb_i    = 1'b0;
        we_i     = 1'b0;
        adr_i    = '0;
        dat_i    = '0;
        sel_i    = '0;
        gpio_i   = '0;
        repeat (5) @(posedge sys_clk);
        #2;
        arst_n_i = 1'b1;

        test_reset();
        test_ram();
        test_gpio();
        test_timer();
        test_errors();

        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, fail_count, err_count);
        if (fail_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/soc_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module soc_top (
    input  logic                sys_clk,
    input  logic                arst_n_i,
    // Pipelined Wishbone master port
    input  logic                cyc_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  soc_pkg::wb_addr_t   adr_i,
    input  soc_pkg::word_t      dat_i,
    input  soc_pkg::byte_sel_t  sel_i,
    output logic                ack_o,
    output logic                err_o,
    output soc_pkg::word_t      dat_o,
    // Pins
    input  soc_pkg::gpio_t      gpio_i,
    output soc_pkg::gpio_t      gpio_o,
    output logic                timer_irq_o
);
    import soc_pkg::*;

    // Request fields shared by both targets
    logic      s_we;
    wb_addr_t  s_adr;
    word_t     s_wdata;
    byte_sel_t s_sel;

    logic  ram_stb, ram_ack;
    word_t ram_rdata;

    logic  periph_stb, periph_ack, periph_err;
    word_t periph_rdata;

    bus_decoder u_dec (
        .sys_clk        (sys_clk),
        .arst_n_i       (arst_n_i),
        .cyc_i          (cyc_i),
        .stb_i          (stb_i),
        .we_i           (we_i),
        .adr_i          (adr_i),
        .dat_i          (dat_i),
        .sel_i          (sel_i),
        .ack_o          (ack_o),
        .err_o          (err_o),
        .dat_o          (dat_o),
        .s_we_o         (s_we),
        .s_adr_o        (s_adr),
        .s_wdata_o      (s_wdata),
        .s_sel_o        (s_sel),
        .ram_stb_o      (ram_stb),
        .ram_ack_i      (ram_ack),
        .ram_rdata_i    (ram_rdata),
        .periph_stb_o   (periph_stb),
        .periph_ack_i   (periph_ack),
        .periph_err_i   (periph_err),
        .periph_rdata_i (periph_rdata)
    );

    wb_ram u_ram (
        .sys_clk  (sys_clk),
        .arst_n_i (arst_n_i),
        .stb_i    (ram_stb),
        .we_i     (s_we),
        .addr_i   (s_adr[`RAM_AW-1:0]), // Window offset only
        .wdata_i  (s_wdata),
        .sel_i    (s_sel),
        .ack_o    (ram_ack),
        .rdata_o  (ram_rdata)
    );

    periph_bus u_periph (
        .sys_clk     (sys_clk),
        .arst_n_i    (arst_n_i),
        .stb_i       (periph_stb),
        .we_i        (s_we),
        .adr_i       (s_adr),
        .wdata_i     (s_wdata),
        .sel_i       (s_sel),
        .ack_o       (periph_ack),
        .err_o       (periph_err),
        .rdata_o     (periph_rdata),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .timer_irq_o (timer_irq_o)
    );

endmodule

`default_nettype wire

// ==== hdl/bus_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module bus_decoder (
    input  logic                sys_clk,
    input  logic                arst_n_i,
    // Master side
    input  logic                cyc_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  soc_pkg::wb_addr_t   adr_i,
    input  soc_pkg::word_t      dat_i,
    input  soc_pkg::byte_sel_t  sel_i,
    output logic                ack_o,
    output logic                err_o,
    output soc_pkg::word_t      dat_o,
    // Request fields common to all targets
    output logic                s_we_o,
    output soc_pkg::wb_addr_t   s_adr_o,
    output soc_pkg::word_t      s_wdata_o,
    output soc_pkg::byte_sel_t  s_sel_o,
    // RAM side
    output logic                ram_stb_o,
    input  logic                ram_ack_i,
    input  soc_pkg::word_t      ram_rdata_i,
    // Peripheral side
    output logic                periph_stb_o,
    input  logic                periph_ack_i,
    input  logic                periph_err_i,
    input  soc_pkg::word_t      periph_rdata_i
);
    import soc_pkg::*;

    logic    req;
    logic    hit_ram;
    logic    hit_periph;
    target_t tgt_d;
    target_t tgt_q; // Owner of the response due this cycle

    assign req        = cyc_i & stb_i;
    assign hit_ram    = (adr_i & `RAM_MASK) == `RAM_BASE;
    assign hit_periph = (adr_i & `PERIPH_MASK) == `PERIPH_BASE;

    always_comb
    begin
        if (!req)
            tgt_d = `TGT_NONE;
        else if (hit_ram)
            tgt_d = `TGT_RAM;
        else if (hit_periph)
            tgt_d = `TGT_PERIPH;
        else
            tgt_d = `TGT_ERR; // Unmapped, answered here
    end

    assign ram_stb_o    = (tgt_d == `TGT_RAM);
    assign periph_stb_o = (tgt_d == `TGT_PERIPH);

    // Address, data and select fan out unchanged
    assign s_we_o    = we_i;
    assign s_adr_o   = adr_i;
    assign s_wdata_o = dat_i;
    assign s_sel_o   = sel_i;

    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            tgt_q <= `TGT_NONE;
        else
            tgt_q <= tgt_d;
    end

    // Each target answers exactly one cycle after its strobe
    assign ack_o = ((tgt_q == `TGT_RAM) & ram_ack_i)
                 | ((tgt_q == `TGT_PERIPH) & periph_ack_i);
    assign err_o = (tgt_q == `TGT_ERR)
                 | ((tgt_q == `TGT_PERIPH) & periph_err_i);

    always_comb
    begin
        case (tgt_q)
            `TGT_RAM:    dat_o = ram_rdata_i;
            `TGT_PERIPH: dat_o = periph_rdata_i;
            default:     dat_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/periph_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module periph_bus (
    input  logic                sys_clk,
    input  logic                arst_n_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  soc_pkg::wb_addr_t   adr_i,
    input  soc_pkg::word_t      wdata_i,
    input  soc_pkg::byte_sel_t  sel_i,
    output logic                ack_o,
    output logic                err_o,
    output soc_pkg::word_t      rdata_o,
    input  soc_pkg::gpio_t      gpio_i,
    output soc_pkg::gpio_t      gpio_o,
    output logic                timer_irq_o
);
    import soc_pkg::*;

    logic       hit_gpio;
    logic       hit_timer;
    logic [1:0] reg_idx;     // Word within a 16-byte window
    logic       timer_wr;
    word_t      timer_rdata;
    word_t      rd_d;
    gpio_t      gpio_out_q;
    gpio_t      gpio_in_q;

    assign hit_gpio  = (adr_i & `GPIO_MASK) == `GPIO_BASE;
    assign hit_timer = (adr_i & `TIMER_MASK) == `TIMER_BASE;
    assign reg_idx   = adr_i[1:0];
    assign timer_wr  = stb_i & we_i & hit_timer;

    wb_timer u_timer (
        .sys_clk  (sys_clk),
        .arst_n_i (arst_n_i),
        .wr_i     (timer_wr),
        .reg_i    (adr_i[0]),  // Words 2 and 3 alias 0 and 1
        .wdata_i  (wdata_i),
        .rdata_o  (timer_rdata),
        .irq_o    (timer_irq_o)
    );

    // GPIO output register, low byte lane only
    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            gpio_out_q <= '0;
        else if (stb_i && we_i && hit_gpio && reg_idx == `GPIO_REG_OUT && sel_i[0])
            gpio_out_q <= wdata_i[7:0];
    end

    assign gpio_o = gpio_out_q;

    // Input pins sampled every cycle
    always_ff @(posedge sys_clk)
    begin
        gpio_in_q <= gpio_i;
    end

    always_comb
    begin
        rd_d = '0;
        if (hit_gpio)
        begin
            if (reg_idx == `GPIO_REG_OUT)
                rd_d = {{(`SOC_DW-8){1'b0}}, gpio_out_q};
            else if (reg_idx == `GPIO_REG_IN)
                rd_d = {{(`SOC_DW-8){1'b0}}, gpio_in_q};
        end
        else if (hit_timer)
            rd_d = timer_rdata;
    end

    // Response one cycle after the strobe
    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
        end
        else
        begin
            ack_o <= stb_i & (hit_gpio | hit_timer);
            err_o <= stb_i & ~(hit_gpio | hit_timer); // Hole in peripheral space
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (stb_i)
            rdata_o <= rd_d;
    end

endmodule

`default_nettype wire

// ==== hdl/wb_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module wb_ram (
    input  logic                sys_clk,
    input  logic                arst_n_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  soc_pkg::ram_addr_t  addr_i,
    input  soc_pkg::word_t      wdata_i,
    input  soc_pkg::byte_sel_t  sel_i,
    output logic                ack_o,
    output soc_pkg::word_t      rdata_o
);
    import soc_pkg::*;

    word_t mem [0:(1 << `RAM_AW)-1];

    // Byte lane writes and a registered read port
    always_ff @(posedge sys_clk)
    begin
        if (stb_i)
        begin
            if (we_i)
            begin
                for (int i = 0; i < `SOC_SELW; i++)
                begin
                    if (sel_i[i])
                        mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
            rdata_o <= mem[addr_i]; // Old word on a write, unused then
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
            ack_o <= 1'b0;
        else
            ack_o <= stb_i;
    end

endmodule

`default_nettype wire

// ==== hdl/wb_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module wb_timer (
    input  logic            sys_clk,
    input  logic            arst_n_i,
    input  logic            wr_i,
    input  logic            reg_i,
    input  soc_pkg::word_t  wdata_i,
    output soc_pkg::word_t  rdata_o,
    output logic            irq_o
);
    import soc_pkg::*;

    word_t count_q;
    word_t cmp_q;
    logic  armed_q;  // Set by the first compare write
    logic  match_q;

    always_ff @(posedge sys_clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            count_q <= '0;
            cmp_q   <= '0;
            armed_q <= 1'b0;
            match_q <= 1'b0;
        end
        else
        begin
            if (wr_i && reg_i == `TIMER_REG_COUNT)
                count_q <= wdata_i;
            else
                count_q <= count_q + 1'b1; // Free running

            if (wr_i && reg_i == `TIMER_REG_CMP)
            begin
                cmp_q   <= wdata_i;
                armed_q <= 1'b1;
                match_q <= 1'b0;
            end
            else if (armed_q && count_q == cmp_q)
                match_q <= 1'b1; // Sticky until the next compare write
        end
    end

    assign rdata_o = (reg_i == `TIMER_REG_CMP) ? cmp_q : count_q;
    assign irq_o   = match_q;

endmodule

`default_nettype wire

// ==== hdl/soc_pkg.sv ====
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

    // Word address as seen on the bus
    typedef logic [`SOC_AW-1:0]   wb_addr_t;

    typedef logic [`SOC_DW-1:0]   word_t;     // Read and write data
    typedef logic [`SOC_SELW-1:0] byte_sel_t; // One bit per byte lane

    // Index into the data RAM
    typedef logic [`RAM_AW-1:0]   ram_addr_t;

    // Holds one of the TGT_* codes
    typedef logic [1:0]           target_t;

    typedef logic [7:0]           gpio_t;

endpackage

`default_nettype wire

// ==== hdl/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus geometry, word addressing
`define SOC_AW   28
`define SOC_DW   32
`define SOC_SELW 4

// On-chip data RAM, 1K words
`define RAM_AW   10

// Root windows, byte values turned into word values
`define RAM_BASE    `SOC_AW'(32'h0000_0000 >> 2)
`define RAM_MASK    `SOC_AW'(~(32'h0000_0FFF >> 2))
`define PERIPH_BASE `SOC_AW'(32'h1000_0000 >> 2)
`define PERIPH_MASK `SOC_AW'(~(32'h000F_FFFF >> 2))

// Peripheral windows, 16 bytes each
`define GPIO_BASE   `SOC_AW'(32'h1000_0000 >> 2)
`define GPIO_MASK   `SOC_AW'(~(32'h0000_000F >> 2))
`define TIMER_BASE  `SOC_AW'(32'h1002_0000 >> 2)
`define TIMER_MASK  `SOC_AW'(~(32'h0000_000F >> 2))

// Word index inside a window
`define GPIO_REG_OUT    2'd0
`define GPIO_REG_IN     2'd1
`define TIMER_REG_COUNT 1'b0
`define TIMER_REG_CMP   1'b1

// Which target owns the response of the previous cycle
`define TGT_NONE   2'd0
`define TGT_RAM    2'd1
`define TGT_PERIPH 2'd2
`define TGT_ERR    2'd3

`endif
